// File: hdl/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

////////////////////
// Data format
`define CONV_DATA_WIDTH      16
`define CONV_FRAC_BITS       8
`define CONV_ACC_WIDTH       40

////////////////////
// Layer shape
`define CONV_CHANNEL_NUM_IN  4
`define CONV_CHANNEL_NUM_OUT 4
// Only sizes the test frame
`define CONV_IMAGE_WIDTH     2

////////////////////
// Output buffering
`define CONV_FIFO_DEPTH      8
// Stages from beat issue to FIFO write
`define CONV_PIPE_DEPTH      2

`endif

// File: hdl/conv_pkg.sv
`include "conv_defines.svh"

package conv_pkg;

  // Fixed-point data words
  typedef logic signed [`CONV_DATA_WIDTH-1:0]   pxl_t;
  typedef logic signed [`CONV_DATA_WIDTH-1:0]   weight_t;
  typedef logic signed [2*`CONV_DATA_WIDTH-1:0] prod_t;
  typedef logic signed [`CONV_ACC_WIDTH-1:0]    acc_t;

  // Index into the weight buffer in output channel major order
  typedef logic [$clog2(`CONV_CHANNEL_NUM_OUT*`CONV_CHANNEL_NUM_IN)-1:0] w_addr_t;

  // One replayed input channel with flags marking the ends of an output channel
  typedef struct packed {
    pxl_t    data;
    w_addr_t waddr;
    logic    first;
    logic    last;
  } conv_beat_t;

  typedef struct packed {
    prod_t product;
    logic  first;
    logic  last;
  } prod_beat_t;

  typedef enum logic {COLLECT, REPLAY} loop_state_t;

endpackage

// File: hdl/conv_loop_data_in.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_loop_data_in (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 pxl_valid,
  input  conv_pkg::pxl_t       pxl_data,
  input  logic                 weights_loaded,
  input  logic                 fifo_space,
  output logic                 pxl_ready,
  output conv_pkg::conv_beat_t beat,
  output logic                 beat_valid
);

  import conv_pkg::*;

  localparam int IC_W = $clog2(`CONV_CHANNEL_NUM_IN);
  localparam int OC_W = $clog2(`CONV_CHANNEL_NUM_OUT);
  localparam logic [IC_W-1:0] IC_LAST = IC_W'(`CONV_CHANNEL_NUM_IN - 1);
  localparam logic [OC_W-1:0] OC_LAST = OC_W'(`CONV_CHANNEL_NUM_OUT - 1);

  loop_state_t     state;
  logic [IC_W-1:0] ic_cnt;
  logic [OC_W-1:0] oc_cnt;
  pxl_t            pxl_buf [`CONV_CHANNEL_NUM_IN];

  logic pxl_fire;

  // New pixel only once the weights are in place
  assign pxl_ready  = (state == COLLECT) && weights_loaded;
  assign pxl_fire   = pxl_valid && pxl_ready;
  // Issue stalls while the output FIFO could overflow
  assign beat_valid = (state == REPLAY) && fifo_space;

  always_comb begin
    beat.data  = pxl_buf[ic_cnt];
    beat.waddr = w_addr_t'(oc_cnt * `CONV_CHANNEL_NUM_IN + ic_cnt);
    beat.first = (ic_cnt == '0);
    beat.last  = (ic_cnt == IC_LAST);
  end

  ////////////////////
  // Pixel store
  always_ff @(posedge clk) begin
    if (pxl_fire) begin
      pxl_buf[ic_cnt] <= pxl_data;
    end
  end

  ////////////////////
  // Collect / replay FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= COLLECT;
      ic_cnt <= '0;
      oc_cnt <= '0;
    end else begin
      case (state)
        COLLECT: begin
          if (pxl_fire) begin
            if (ic_cnt == IC_LAST) begin
              ic_cnt <= '0;
              state  <= REPLAY;
            end else begin
              ic_cnt <= ic_cnt + 1'b1;
            end
          end
        end
        REPLAY: begin
          if (beat_valid) begin
            if (ic_cnt == IC_LAST) begin
              ic_cnt <= '0;
              if (oc_cnt == OC_LAST) begin
                // Final beat of the pixel
                oc_cnt <= '0;
                state  <= COLLECT;
              end else begin
                oc_cnt <= oc_cnt + 1'b1;
              end
            end else begin
              ic_cnt <= ic_cnt + 1'b1;
            end
          end
        end
        default: state <= COLLECT;
      endcase
    end
  end

endmodule

// File: hdl/conv_1x1_mac.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_1x1_mac (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 weight_valid,
  input  conv_pkg::weight_t    weight_data,
  input  conv_pkg::conv_beat_t beat,
  input  logic                 beat_valid,
  output logic                 weight_ready,
  output logic                 weights_loaded,
  output conv_pkg::prod_beat_t prod,
  output logic                 prod_valid
);

  import conv_pkg::*;

  localparam int      W_NUM  = `CONV_CHANNEL_NUM_OUT * `CONV_CHANNEL_NUM_IN;
  localparam w_addr_t W_LAST = w_addr_t'(W_NUM - 1);

  weight_t weight_buf [W_NUM];
  w_addr_t load_ptr;

  logic    weight_fire;
  weight_t sel_weight;
  pxl_t    sel_data;
  prod_t   product;

  // Buffer accepts weights until the last entry is written
  assign weight_ready = !weights_loaded;
  assign weight_fire  = weight_valid && weight_ready;

  ////////////////////
  // Weight load
  always_ff @(posedge clk) begin
    if (weight_fire) begin
      weight_buf[load_ptr] <= weight_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      load_ptr       <= '0;
      weights_loaded <= 1'b0;
    end else if (weight_fire) begin
      if (load_ptr == W_LAST) begin
        weights_loaded <= 1'b1;
      end else begin
        load_ptr <= load_ptr + 1'b1;
      end
    end
  end

  ////////////////////
  // Multiply
  assign sel_weight = weight_buf[beat.waddr];
  assign sel_data   = beat.data;
  // Full-precision signed product without rounding
  assign product    = prod_t'(sel_data) * prod_t'(sel_weight);

  always_ff @(posedge clk) begin
    if (beat_valid) begin
      prod.product <= product;
      prod.first   <= beat.first;
      prod.last    <= beat.last;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= beat_valid;
    end
  end

endmodule

// File: hdl/conv_channel_adder.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_channel_adder (
  input  logic                 clk,
  input  logic                 reset,
  input  conv_pkg::prod_beat_t prod,
  input  logic                 prod_valid,
  output conv_pkg::pxl_t       sum_data,
  output logic                 sum_valid
);

  import conv_pkg::*;

  // Limits of the output word in accumulator width
  localparam acc_t SAT_MAX = acc_t'(2**(`CONV_DATA_WIDTH-1) - 1);
  localparam acc_t SAT_MIN = acc_t'(-(2**(`CONV_DATA_WIDTH-1)));

  acc_t acc;
  acc_t acc_next;
  acc_t scaled;
  pxl_t sat;

  always_comb begin
    // First product restarts the sum
    if (prod.first) begin
      acc_next = acc_t'(prod.product);
    end else begin
      acc_next = acc + acc_t'(prod.product);
    end
    // Floor toward minus infinity
    scaled = acc_next >>> `CONV_FRAC_BITS;
    if (scaled > SAT_MAX) begin
      sat = pxl_t'(SAT_MAX);
    end else if (scaled < SAT_MIN) begin
      sat = pxl_t'(SAT_MIN);
    end else begin
      sat = pxl_t'(scaled);
    end
  end

  ////////////////////
  // Accumulate
  always_ff @(posedge clk) begin
    if (prod_valid) begin
      acc <= acc_next;
      if (prod.last) begin
        sum_data <= sat;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= prod_valid && prod.last;
    end
  end

endmodule

// File: hdl/conv_out_fifo.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_out_fifo (
  input  logic           clk,
  input  logic           reset,
  input  logic           wr_valid,
  input  conv_pkg::pxl_t wr_data,
  input  logic           issue_last,
  input  logic           out_ready,
  output logic           out_valid,
  output conv_pkg::pxl_t out_data,
  output logic           fifo_space
);

  import conv_pkg::*;

  localparam int PTR_W = $clog2(`CONV_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`CONV_FIFO_DEPTH + 1);
  localparam int INF_W = $clog2(`CONV_PIPE_DEPTH + 1);

  pxl_t             mem [`CONV_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  // Results issued upstream but not yet written here
  logic [INF_W-1:0] inflight;
  logic [CNT_W:0]   occupied;
  logic             rd_fire;

  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign rd_fire   = out_valid && out_ready;

  // Reserve a slot for every result still in the pipeline
  assign occupied   = {1'b0, count} + (CNT_W+1)'(inflight);
  assign fifo_space = (occupied < (CNT_W+1)'(`CONV_FIFO_DEPTH));

  ////////////////////
  // Storage
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      inflight <= '0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count    <= count + CNT_W'(wr_valid) - CNT_W'(rd_fire);
      inflight <= inflight + INF_W'(issue_last) - INF_W'(wr_valid);
    end
  end

endmodule

// File: hdl/cnn_conv_1x1.sv
`timescale 1ns/1ps

module cnn_conv_1x1 (
  input  logic              clk,
  input  logic              reset,
  input  logic              weight_valid,
  input  conv_pkg::weight_t weight_data,
  output logic              weight_ready,
  input  logic              pxl_valid,
  input  conv_pkg::pxl_t    pxl_data,
  output logic              pxl_ready,
  output logic              out_valid,
  output conv_pkg::pxl_t    out_data,
  input  logic              out_ready
);

  import conv_pkg::*;

  logic       weights_loaded;
  logic       fifo_space;
  conv_beat_t beat;
  logic       beat_valid;
  prod_beat_t prod;
  logic       prod_valid;
  pxl_t       sum_data;
  logic       sum_valid;

  ////////////////////
  // Replay pixels per output channel
  conv_loop_data_in loop_i (
    .clk           (clk),
    .reset         (reset),
    .pxl_valid     (pxl_valid),
    .pxl_data      (pxl_data),
    .weights_loaded(weights_loaded),
    .fifo_space    (fifo_space),
    .pxl_ready     (pxl_ready),
    .beat          (beat),
    .beat_valid    (beat_valid)
  );

  conv_1x1_mac mac_i (
    .clk           (clk),
    .reset         (reset),
    .weight_valid  (weight_valid),
    .weight_data   (weight_data),
    .beat          (beat),
    .beat_valid    (beat_valid),
    .weight_ready  (weight_ready),
    .weights_loaded(weights_loaded),
    .prod          (prod),
    .prod_valid    (prod_valid)
  );

  conv_channel_adder add_i (
    .clk       (clk),
    .reset     (reset),
    .prod      (prod),
    .prod_valid(prod_valid),
    .sum_data  (sum_data),
    .sum_valid (sum_valid)
  );

  // FIFO tracks results in flight from the issue port
  conv_out_fifo fifo_i (
    .clk       (clk),
    .reset     (reset),
    .wr_valid  (sum_valid),
    .wr_data   (sum_data),
    .issue_last(beat_valid && beat.last),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .fifo_space(fifo_space)
  );

endmodule

// File: tests/cnn_conv_1x1_assertions.sv
`timescale 1ns/1ps

module cnn_conv_1x1_assertions (
  input logic           clk,
  input logic           reset,
  input logic           weight_ready,
  input logic           pxl_ready,
  input logic           beat_valid,
  input logic           prod_valid,
  input logic           sum_valid,
  input logic           out_valid,
  input conv_pkg::pxl_t out_data,
  input logic           out_ready
);

  // Assertion failure tally
  int fail_count = 0;

  ////////////////////
  // Output handshake
  out_stable_a : assert property (
    @(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else begin
    fail_count++;
    $error("out_valid or out_data changed while the output was stalled");
  end

  ////////////////////
  // Weight load order
  pxl_wait_a : assert property (
    @(posedge clk) disable iff (reset)
    weight_ready |-> !pxl_ready
  ) else begin
    fail_count++;
    $error("pxl_ready high before all weights were loaded");
  end

  // Weights load once per reset
  weight_ready_once_a : assert property (
    @(posedge clk) disable iff (reset)
    !weight_ready |=> !weight_ready
  ) else begin
    fail_count++;
    $error("weight_ready rose again after the weight load");
  end

  // First cycle out of reset
  reset_idle_a : assert property (
    @(posedge clk)
    $fell(reset) |-> weight_ready && !pxl_ready && !beat_valid && !prod_valid
      && !sum_valid && !out_valid
  ) else begin
    fail_count++;
    $error("control output not idle in the first cycle after reset");
  end

endmodule

// File: tests/cnn_conv_1x1_tb.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module cnn_conv_1x1_tb;

  import conv_pkg::*;

  localparam int PIXELS     = `CONV_IMAGE_WIDTH * `CONV_IMAGE_WIDTH;
  localparam int W_NUM      = `CONV_CHANNEL_NUM_OUT * `CONV_CHANNEL_NUM_IN;
  localparam int PXL_NUM    = PIXELS * `CONV_CHANNEL_NUM_IN;
  localparam int OUT_NUM    = PIXELS * `CONV_CHANNEL_NUM_OUT;
  localparam int CLK_PERIOD = 8;
  localparam int WATCHDOG_CYCLES = (W_NUM + PXL_NUM * `CONV_CHANNEL_NUM_OUT + OUT_NUM) * 8;

  logic    clk;
  logic    reset;
  logic    weight_valid;
  weight_t weight_data;
  logic    weight_ready;
  logic    pxl_valid;
  pxl_t    pxl_data;
  logic    pxl_ready;
  logic    out_valid;
  pxl_t    out_data;
  logic    out_ready;

  // Weights, then pixels, then expected results
  logic [15:0] golden [W_NUM + PXL_NUM + OUT_NUM];
  integer      seed;
  int          errors;

  cnn_conv_1x1 dut_i (
    .clk         (clk),
    .reset       (reset),
    .weight_valid(weight_valid),
    .weight_data (weight_data),
    .weight_ready(weight_ready),
    .pxl_valid   (pxl_valid),
    .pxl_data    (pxl_data),
    .pxl_ready   (pxl_ready),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_ready   (out_ready)
  );

  bind cnn_conv_1x1 cnn_conv_1x1_assertions assertions_i (
    .clk(clk), .reset(reset), .weight_ready(weight_ready), .pxl_ready(pxl_ready),
    .beat_valid(beat_valid), .prod_valid(prod_valid), .sum_valid(sum_valid),
    .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: results missing after %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic check_equal(input logic [15:0] actual, input logic [15:0] expected,
                             input string msg);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic int gap_len(input bit enable);
    if (!enable) begin
      return 0;
    end
    return $unsigned($random(seed)) % 3;
  endfunction

  ////////////////////
  // Stream drivers
  task automatic send_weights(input bit gaps);
    int gap;
    for (int k = 0; k < W_NUM; k++) begin
      gap = gap_len(gaps);
      weight_valid = 1'b0;
      repeat (gap) next_cycle();
      weight_valid = 1'b1;
      weight_data  = golden[k];
      @(negedge clk);
      check_equal(16'(weight_ready), 16'd1, $sformatf("weight_ready for weight %0d", k));
      check_equal(16'(pxl_ready), 16'd0, "pxl_ready during weight load");
      next_cycle();
    end
    weight_valid = 1'b0;
    @(negedge clk);
    check_equal(16'(weight_ready), 16'd0, "weight_ready after the last weight");
    next_cycle();
  endtask

  task automatic send_pixels(input bit gaps);
    int gap;
    for (int k = 0; k < PXL_NUM; k++) begin
      gap = gap_len(gaps);
      pxl_valid = 1'b0;
      repeat (gap) next_cycle();
      pxl_valid = 1'b1;
      pxl_data  = golden[W_NUM + k];
      @(negedge clk);
      while (!pxl_ready) @(negedge clk);
      next_cycle();
    end
    pxl_valid = 1'b0;
  endtask

  task automatic collect_outputs(input bit stalls);
    int n;
    n = 0;
    while (n < OUT_NUM) begin
      // Mostly stalled so the FIFO fills and issue has to wait for space
      out_ready = stalls ? ($unsigned($random(seed)) % 16 == 0) : 1'b1;
      @(negedge clk);
      if (out_valid && out_ready) begin
        check_equal(out_data, golden[W_NUM + PXL_NUM + n], $sformatf("result %0d", n));
        n++;
      end
      next_cycle();
    end
    out_ready = 1'b1;
    // Nothing may follow the last result
    repeat (2 * `CONV_PIPE_DEPTH + 4) begin
      @(negedge clk);
      check_equal(16'(out_valid), 16'd0, "out_valid after the last result");
    end
    next_cycle();
  endtask

  task automatic run_pass(input bit random_timing);
    reset = 1'b1;
    repeat (5) next_cycle();
    reset = 1'b0;
    fork
      begin
        send_weights(random_timing);
        send_pixels(random_timing);
      end
      collect_outputs(random_timing);
    join
  endtask

  initial begin
    seed         = 32'h9794;
    errors       = 0;
    reset        = 1'b1;
    weight_valid = 1'b0;
    weight_data  = '0;
    pxl_valid    = 1'b0;
    pxl_data     = '0;
    out_ready    = 1'b0;
    $readmemh("tests/conv_golden.txt", golden);
    // Continuous streams, then random gaps and output stalls
    run_pass(1'b0);
    run_pass(1'b1);
    $display("Run finished with %0d check errors and %0d assertion failures", errors,
             dut_i.assertions_i.fail_count);
    if (errors == 0 && dut_i.assertions_i.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+hdl
hdl/conv_pkg.sv
hdl/conv_loop_data_in.sv
hdl/conv_1x1_mac.sv
hdl/conv_channel_adder.sv
hdl/conv_out_fifo.sv
hdl/cnn_conv_1x1.sv
tests/cnn_conv_1x1_assertions.sv
tests/cnn_conv_1x1_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module cnn_conv_1x1_tb -f compile.f
	./obj_dir/Vcnn_conv_1x1_tb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "SOME TESTS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/conv_golden.txt
// Four 16-bit Q8.8 words per row. Weight and pixel rows hold input channels 0..3,
// result rows hold output channels 0..3
// Weights w[o][i], one row per output channel
0100 0100 0100 0100
0080 FF80 0040 0200
7F00 7F00 7F00 7F00
8100 0000 0000 FF40
// Pixels, one row per pixel
0100 0200 0300 0400
FE80 00C0 FDC0 0080
6400 3200 0A00 0000
0001 FFFF 0003 FFFB
// Expected results, one row per pixel
0A00 0840 7FFF 8000
FD80 FF50 8000 7FFF
7FFF 1B80 7FFF 8000
// Last row floors -8.25 to -9 and -123.25 to -124
FFFE FFF7 FF02 FF84
